// File: rtl/boxsum_pkg.sv
`default_nettype none

package boxsum_pkg;

    // frame geometry
    localparam int COLS = 19;
    localparam int WIN  = 16;
    localparam int ROWS = 4;

    // datapath widths
    localparam int SAMPLE_W = 8;
    localparam int SUM_W    = 12;
    localparam int COL_W    = 5;
    localparam int ROW_W    = 2;

    // largest value one sample can carry
    localparam int SAMPLE_MAX = (1 << SAMPLE_W) - 1;

    // largest possible window sum, must fit in SUM_W bits
    localparam int SUM_MAX = WIN * SAMPLE_MAX;

    // one input pixel
    typedef logic [SAMPLE_W-1:0] sample_t;

    // sequencer phases
    //   idle      waiting for start
    //   row_start one cycle to clear window and column count
    //   fill      first WIN-1 samples of a row, no output yet
    //   slide     one result per accepted sample
    //   finish    one cycle, frame_done is high
    typedef enum logic [2:0] {
        SEQ_IDLE      = 3'd0,
        SEQ_ROW_START = 3'd1,
        SEQ_FILL      = 3'd2,
        SEQ_SLIDE     = 3'd3,
        SEQ_FINISH    = 3'd4
    } seq_state_t;

    // tagged window result
    // col is the index of the newest sample in the window
    typedef struct packed {
        logic [SUM_W-1:0] sum;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } win_result_t;

endpackage

`default_nettype wire

// File: rtl/sample_handshake.sv
`default_nettype none

module sample_handshake import boxsum_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    accept_en,
    input  logic    sample_req,
    input  sample_t sample_data,
    output logic    sample_ack,
    output logic    sample_strobe,
    output sample_t sample_value
);

    logic take;

    // ack low is the waiting state, ack high is the acked state
    // a new request is taken only from the waiting state
    assign take = sample_req && accept_en && !sample_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_ack <= 1'b0;
        end else if (take) begin
            sample_ack <= 1'b1;
        end else if (sample_ack && !sample_req) begin
            // host released req, close the four-phase cycle
            sample_ack <= 1'b0;
        end
    end

    // strobe marks the single cycle in which ack has just risen
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= take;
        end
    end

    // data is captured together with the ack rise
    always_ff @(posedge clk) begin
        if (take) begin
            sample_value <= sample_data;
        end
    end

    // the sequencer must have opened the input before an ack goes out
    a_ack_needs_accept: assert property (
        @(posedge clk) disable iff (rst)
        $rose(sample_ack) |-> $past(accept_en)
    );

endmodule

`default_nettype wire

// File: rtl/row_sequencer.sv
`default_nettype none

module row_sequencer import boxsum_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic sample_strobe,
    input  logic fill_end,
    input  logic row_end,
    input  logic row_last,
    output logic accept_en,
    output logic row_load,
    output logic emit_en,
    output logic frame_clear,
    output logic frame_done
);

    seq_state_t state_q;
    seq_state_t state_d;

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                // start outside idle is ignored
                if (start) begin
                    state_d = SEQ_ROW_START;
                end
            end
            SEQ_ROW_START: begin
                state_d = SEQ_FILL;
            end
            SEQ_FILL: begin
                // sample WIN-2 completes the fill, the next one gives a full window
                if (sample_strobe && fill_end) begin
                    state_d = SEQ_SLIDE;
                end
            end
            SEQ_SLIDE: begin
                if (sample_strobe && row_end) begin
                    if (row_last) begin
                        state_d = SEQ_FINISH;
                    end else begin
                        state_d = SEQ_ROW_START;
                    end
                end
            end
            SEQ_FINISH: begin
                state_d = SEQ_IDLE;
            end
            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    // control decode
    always_comb begin
        accept_en   = 1'b0;
        row_load    = 1'b0;
        emit_en     = 1'b0;
        frame_clear = 1'b0;
        frame_done  = 1'b0;
        case (state_q)
            SEQ_IDLE: begin
                // row counter is cleared on the edge that leaves idle
                frame_clear = start;
            end
            SEQ_ROW_START: begin
                row_load = 1'b1;
            end
            SEQ_FILL: begin
                accept_en = 1'b1;
            end
            SEQ_SLIDE: begin
                accept_en = 1'b1;
                emit_en   = 1'b1;
            end
            SEQ_FINISH: begin
                frame_done = 1'b1;
            end
            default: begin
                accept_en = 1'b0;
            end
        endcase
    end

    // frame_done is a single-cycle pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        frame_done |=> !frame_done
    );

    // state register holds only defined phases
    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state_q inside {SEQ_IDLE, SEQ_ROW_START, SEQ_FILL, SEQ_SLIDE, SEQ_FINISH}
    );

endmodule

`default_nettype wire

// File: rtl/position_counters.sv
`default_nettype none

module position_counters import boxsum_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_strobe,
    input  logic             row_load,
    input  logic             frame_clear,
    output logic [COL_W-1:0] col_idx,
    output logic [ROW_W-1:0] row_idx,
    output logic             fill_end,
    output logic             row_end,
    output logic             row_last
);

    // column of the sample currently being accepted
    // it moves past COLS-1 once per row, row_load brings it back
    always_ff @(posedge clk) begin
        if (rst || row_load) begin
            col_idx <= '0;
        end else if (sample_strobe) begin
            col_idx <= col_idx + 1'b1;
        end
    end

    // row advances with the last sample of each row
    always_ff @(posedge clk) begin
        if (rst || frame_clear) begin
            row_idx <= '0;
        end else if (sample_strobe && row_end) begin
            row_idx <= row_idx + 1'b1;
        end
    end

    // position flags for the sequencer
    assign fill_end = (col_idx == COL_W'(WIN - 2));
    assign row_end  = (col_idx == COL_W'(COLS - 1));
    assign row_last = (row_idx == ROW_W'(ROWS - 1));

    // no sample may arrive once the row is complete
    a_col_in_range: assert property (
        @(posedge clk) disable iff (rst)
        sample_strobe |-> (col_idx <= COL_W'(COLS - 1))
    );

endmodule

`default_nettype wire

// File: rtl/window_accumulator.sv
`default_nettype none

module window_accumulator import boxsum_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             row_load,
    input  logic             emit_en,
    input  logic             sample_strobe,
    input  sample_t          sample_value,
    input  logic [COL_W-1:0] col_idx,
    input  logic [ROW_W-1:0] row_idx,
    output win_result_t      result,
    output logic             result_valid
);

    // win_q[0] is the newest sample, win_q[WIN-1] the oldest
    sample_t          win_q [WIN];
    logic [SUM_W-1:0] sum_q;
    logic [SUM_W-1:0] sum_next;

    // the oldest sample is part of sum_q, so the subtraction cannot wrap
    assign sum_next = sum_q + SUM_W'(sample_value) - SUM_W'(win_q[WIN-1]);

    // delay line
    // zeroed at row start, so the first WIN-1 sums are partial
    // and no column test is needed
    always_ff @(posedge clk) begin
        if (rst || row_load) begin
            for (int i = 0; i < WIN; i++) begin
                win_q[i] <= '0;
            end
        end else if (sample_strobe) begin
            win_q[0] <= sample_value;
            for (int i = 1; i < WIN; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    // running sum over the delay line
    always_ff @(posedge clk) begin
        if (rst || row_load) begin
            sum_q <= '0;
        end else if (sample_strobe) begin
            sum_q <= sum_next;
        end
    end

    // result strobe, one cycle per sample taken in slide
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sample_strobe && emit_en;
        end
    end

    // tagged result, held until the next emitted column
    always_ff @(posedge clk) begin
        if (sample_strobe && emit_en) begin
            result.sum <= sum_next;
            result.row <= row_idx;
            result.col <= col_idx;
        end
    end

    // the window never holds more than WIN full-scale samples
    a_sum_bound: assert property (
        @(posedge clk) disable iff (rst)
        sum_q <= SUM_W'(SUM_MAX)
    );

    // results only come out for columns with a full window
    a_full_window: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |-> (result.col >= COL_W'(WIN - 1))
    );

endmodule

`default_nettype wire

// File: rtl/boxsum_top.sv
`default_nettype none

module boxsum_top import boxsum_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        sample_req,
    input  sample_t     sample_data,
    output logic        sample_ack,
    output win_result_t result,
    output logic        result_valid,
    output logic        frame_done
);

    // handshake to datapath
    logic    sample_strobe;
    sample_t sample_value;

    // sequencer controls
    logic accept_en;
    logic row_load;
    logic emit_en;
    logic frame_clear;

    // counter flags and tags
    logic [COL_W-1:0] col_idx;
    logic [ROW_W-1:0] row_idx;
    logic             fill_end;
    logic             row_end;
    logic             row_last;

    sample_handshake u_handshake (
        .clk           (clk),
        .rst           (rst),
        .accept_en     (accept_en),
        .sample_req    (sample_req),
        .sample_data   (sample_data),
        .sample_ack    (sample_ack),
        .sample_strobe (sample_strobe),
        .sample_value  (sample_value)
    );

    row_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .sample_strobe (sample_strobe),
        .fill_end      (fill_end),
        .row_end       (row_end),
        .row_last      (row_last),
        .accept_en     (accept_en),
        .row_load      (row_load),
        .emit_en       (emit_en),
        .frame_clear   (frame_clear),
        .frame_done    (frame_done)
    );

    position_counters u_counters (
        .clk           (clk),
        .rst           (rst),
        .sample_strobe (sample_strobe),
        .row_load      (row_load),
        .frame_clear   (frame_clear),
        .col_idx       (col_idx),
        .row_idx       (row_idx),
        .fill_end      (fill_end),
        .row_end       (row_end),
        .row_last      (row_last)
    );

    window_accumulator u_accumulator (
        .clk           (clk),
        .rst           (rst),
        .row_load      (row_load),
        .emit_en       (emit_en),
        .sample_strobe (sample_strobe),
        .sample_value  (sample_value),
        .col_idx       (col_idx),
        .row_idx       (row_idx),
        .result        (result),
        .result_valid  (result_valid)
    );

endmodule

`default_nettype wire

// File: testbench/tb_boxsum.sv
`default_nettype none

module tb_boxsum import boxsum_pkg::*; ();

    localparam int SEED         = 37885;
    localparam int FRAME_LEN    = ROWS * COLS;
    // abort on the last sample of the frame
    // its result and frame_done would rise on the reset edge
    localparam int ABORT_LEN    = FRAME_LEN - 1;
    localparam int ACK_TIMEOUT  = 50;
    localparam int DONE_TIMEOUT = 50;
    localparam int NUM_FRAMES   = 7;

    localparam logic [1:0] PAT_CONST = 2'd0;
    localparam logic [1:0] PAT_RAMP  = 2'd1;
    localparam logic [1:0] PAT_ALT   = 2'd2;
    localparam logic [1:0] PAT_RAND  = 2'd3;

    localparam logic [7:0] RESULTS_PER_FRAME = 8'(ROWS * (COLS - WIN + 1));

    // one table row: fill pattern, seed value, reset mid-frame, results expected
    typedef struct packed {
        logic [1:0] pattern;
        logic [7:0] base;
        logic       mid_reset;
        logic [7:0] exp_results;
    } frame_cfg_t;

    logic        clk;
    logic        rst;
    logic        start;
    logic        sample_req;
    sample_t     sample_data;
    logic        sample_ack;
    win_result_t result;
    logic        result_valid;
    logic        frame_done;

    frame_cfg_t  frame_table [NUM_FRAMES];
    sample_t     frame_mem [FRAME_LEN];
    win_result_t exp_q [$];

    int   errors;
    int   checks;
    int   done_count;
    int   frames_expected;
    int   frame_results;
    int   exp_results_cur;
    logic hung;

    boxsum_top UUT (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .sample_req   (sample_req),
        .sample_data  (sample_data),
        .sample_ack   (sample_ack),
        .result       (result),
        .result_valid (result_valid),
        .frame_done   (frame_done)
    );

    always #4 clk = ~clk;

    task automatic check_field(input string name, input int unsigned exp_v,
                               input int unsigned got_v);
        checks++;
        assert (exp_v == got_v) else begin
            $display("ERR %s expected 0x%0h got 0x%0h", name, exp_v, got_v);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic fill_frame(input logic [1:0] pattern, input logic [7:0] base);
        for (int i = 0; i < FRAME_LEN; i++) begin
            case (pattern)
                PAT_CONST: frame_mem[i] = base;
                PAT_RAMP:  frame_mem[i] = 8'(32'(base) + i * 7);
                PAT_ALT: begin
                    // even rows bright, odd rows dark
                    if ((i / COLS) % 2 == 0) begin
                        frame_mem[i] = 8'hF0 ^ 8'(i);
                    end else begin
                        frame_mem[i] = 8'h0F & 8'(i);
                    end
                end
                default:   frame_mem[i] = 8'($urandom());
            endcase
        end
    endtask

    // expected sums, window of WIN samples ending at column c, never across rows
    task automatic build_expected();
        win_result_t e;
        int unsigned acc;
        exp_q.delete();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = WIN - 1; c < COLS; c++) begin
                acc = 0;
                for (int k = c - WIN + 1; k <= c; k++) begin
                    acc = acc + 32'(frame_mem[r * COLS + k]);
                end
                e.sum = 12'(acc);
                e.row = 2'(r);
                e.col = 5'(c);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic wait_ack(input logic level);
        int k;
        if (hung) return;
        k = 0;
        while (sample_ack !== level && k < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            k++;
        end
        check_true(sample_ack === level, "timeout waiting for sample_ack to change");
        if (sample_ack !== level) hung = 1'b1;
    endtask

    task automatic send_sample(input sample_t value);
        if (hung) return;
        sample_data = value;
        sample_req  = 1'b1;
        wait_ack(1'b1);
        sample_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic wait_frame_done(input int target);
        int k;
        if (hung) return;
        k = 0;
        while (done_count < target && k < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            k++;
        end
        check_true(done_count >= target, "frame_done not seen within timeout");
        if (done_count < target) hung = 1'b1;
        // a second frame_done would show up here
        repeat (4) @(posedge clk);
        #1;
        check_field("frame_done count", target, done_count);
        check_true(exp_q.size() == 0, "results missing at end of frame");
    endtask

    // reset while a sample is being acked
    task automatic reset_mid_frame();
        if (hung) return;
        sample_data = frame_mem[ABORT_LEN];
        sample_req  = 1'b1;
        wait_ack(1'b1);
        rst = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_field("sample_ack", 0, 32'(sample_ack));
            check_field("result_valid", 0, 32'(result_valid));
            check_field("frame_done", 0, 32'(frame_done));
        end
        sample_req = 1'b0;
        rst        = 1'b0;
        exp_q.delete();
        frame_results = 0;
    endtask

    task automatic run_frame(input frame_cfg_t cfg, input logic abort);
        int n_send;
        if (hung) return;
        fill_frame(cfg.pattern, cfg.base);
        build_expected();
        frame_results = 0;
        n_send = abort ? ABORT_LEN : FRAME_LEN;
        // request held in idle must not be acked before start
        sample_data = frame_mem[0];
        sample_req  = 1'b1;
        repeat (6) begin
            @(posedge clk);
            #1;
            check_field("sample_ack", 0, 32'(sample_ack));
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_ack(1'b1);
        sample_req = 1'b0;
        wait_ack(1'b0);
        for (int i = 1; i < n_send; i++) begin
            send_sample(frame_mem[i]);
        end
        if (abort) begin
            reset_mid_frame();
        end else begin
            frames_expected++;
            wait_frame_done(frames_expected);
        end
    endtask

    // monitor, sampled away from the active edge
    always @(negedge clk) begin : monitor
        win_result_t e;
        if (!rst) begin
            if (result_valid) begin
                frame_results++;
                check_true(exp_q.size() != 0, "extra result with nothing expected");
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    check_field("result.row", 32'(e.row), 32'(result.row));
                    check_field("result.col", 32'(e.col), 32'(result.col));
                    check_field("result.sum", 32'(e.sum), 32'(result.sum));
                end
            end
            if (frame_done) begin
                done_count++;
                // last result and frame_done share a cycle
                check_field("result_valid", 1, 32'(result_valid));
                check_field("result count", exp_results_cur, frame_results);
                frame_results = 0;
            end
        end
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        start           = 1'b0;
        sample_req      = 1'b0;
        sample_data     = '0;
        errors          = 0;
        checks          = 0;
        done_count      = 0;
        frames_expected = 0;
        frame_results   = 0;
        exp_results_cur = 0;
        hung            = 1'b0;
        void'($urandom(SEED));

        frame_table[0] = '{PAT_CONST, 8'h5A, 1'b0, RESULTS_PER_FRAME};
        frame_table[1] = '{PAT_RAMP,  8'h03, 1'b0, RESULTS_PER_FRAME};
        frame_table[2] = '{PAT_ALT,   8'h00, 1'b0, RESULTS_PER_FRAME};
        frame_table[3] = '{PAT_RAND,  8'h00, 1'b0, RESULTS_PER_FRAME};
        frame_table[4] = '{PAT_RAND,  8'h00, 1'b0, RESULTS_PER_FRAME};
        frame_table[5] = '{PAT_CONST, 8'hFF, 1'b1, RESULTS_PER_FRAME};
        frame_table[6] = '{PAT_RAMP,  8'h80, 1'b1, RESULTS_PER_FRAME};

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            exp_results_cur = 32'(frame_table[f].exp_results);
            if (frame_table[f].mid_reset) begin
                run_frame(frame_table[f], 1'b1);
            end
            run_frame(frame_table[f], 1'b0);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/boxsum_pkg.sv
rtl/sample_handshake.sv
rtl/row_sequencer.sv
rtl/position_counters.sv
rtl/window_accumulator.sv
rtl/boxsum_top.sv
testbench/tb_boxsum.sv

// File: run_sim.sh
#!/bin/sh
# build the boxsum testbench with Verilator, run it, judge from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_boxsum -f compile.f \
    -o tb_boxsum_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_boxsum_sim > sim.log 2>&1

grep -q "All tests passed!" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
